//--- design/arb_consts.svh
// shared sizing constants for the arbitration pipeline, included by the RTL and the testbench
`ifndef ARB_CONSTS_SVH
`define ARB_CONSTS_SVH

// number of requesters seen by every job
`define ARB_WIDTH 4

// job entries buffered between sampler and engine
// keep this a power of two
`define ARB_FIFO_DEPTH 4

// reset value of the random-mode mask
// any non-zero value keeps the LFSR out of the all-zero lock
`define ARB_LFSR_SEED 1

`endif

//--- design/arb_mode_pkg.sv
// arbitration mode encoding shared by the job type, the grant engine and the testbench
package arb_mode_pkg;

    // two-bit mode field carried with every job
    typedef enum logic [1:0] {
        // lowest set request index wins
        ARB_FIXED = 2'd0,
        // circular search from the rotating pointer
        ARB_RR    = 2'd1,
        // lowest set index of req and cfg
        ARB_PRIO  = 2'd2,
        // lowest set index of req and the LFSR mask
        ARB_RAND  = 2'd3
    } arb_mode_e;

endpackage

//--- design/arb_job_pkg.sv
// job record passed from the request sampler through the FIFO into the grant engine
`include "arb_consts.svh"

package arb_job_pkg;

    // one arbitration job
    typedef struct packed {
        // requester bits, index 0 is highest priority in fixed mode
        logic [`ARB_WIDTH-1:0]   req;
        // how this job is resolved
        arb_mode_pkg::arb_mode_e mode;
        // enable mask for priority mode
        logic [`ARB_WIDTH-1:0]   cfg;
    } arb_job_t;

endpackage

//--- design/arb_req_sampler.sv
// input stage that captures arbitration jobs on valid/ready and feeds them to the job FIFO
`timescale 1ns/1ps
`include "arb_consts.svh"

module arb_req_sampler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ARB_WIDTH-1:0]   req_i,
    input  arb_mode_pkg::arb_mode_e mode_i,
    input  logic [`ARB_WIDTH-1:0]   cfg_i,
    input  logic                    valid_i,
    input  logic                    full_i,
    output logic                    ready_o,
    output logic                    wr_en_o,
    output arb_job_pkg::arb_job_t   wr_data_o
);

    // job register and its occupied flag
    arb_job_pkg::arb_job_t job_q;
    logic                  have_q;
    logic                  accept;
    logic                  write_done;

    // a held job is refused only while the queue reports full
    assign ready_o    = !(have_q && full_i);
    assign accept     = valid_i && ready_o;
    assign write_done = have_q && !full_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_q <= 1'b0;
        end else if (accept) begin
            have_q <= 1'b1;
        end else if (write_done) begin
            have_q <= 1'b0;
        end
    end

    // payload register, loaded only on a handshake
    always_ff @(posedge clk) begin
        if (accept) begin
            job_q.req  <= req_i;
            job_q.mode <= mode_i;
            job_q.cfg  <= cfg_i;
        end
    end

    assign wr_en_o   = have_q;
    assign wr_data_o = job_q;

    // refused job must be presented unchanged until the queue takes it
    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (wr_en_o && full_i) |=> (wr_en_o && $stable(wr_data_o))
    ) else $error("sampler changed a held job while the queue was full");

endmodule

//--- design/arb_job_fifo.sv
// synchronous FIFO with a type-parameter payload and first-word-fall-through head output
`timescale 1ns/1ps
`include "arb_consts.svh"

module arb_job_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `ARB_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     wr_en_i,
    input  payload_t wr_data_i,
    input  logic     rd_en_i,
    output payload_t rd_data_o,
    output logic     full_o,
    output logic     empty_o
);

    localparam int AW = $clog2(DEPTH);

    // storage, no reset on entries
    payload_t mem [DEPTH];

    // pointers carry one wrap bit above the index
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] level;
    logic        wr_fire;
    logic        rd_fire;

    assign level   = wr_ptr - rd_ptr;
    assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign empty_o = (wr_ptr == rd_ptr);

    // requests against full or empty are simply ignored
    assign wr_fire = wr_en_i && !full_o;
    assign rd_fire = rd_en_i && !empty_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_fire) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[AW-1:0]] <= wr_data_i;
        end
    end

    // head entry visible before the pop
    assign rd_data_o = mem[rd_ptr[AW-1:0]];

    // occupancy never runs past the storage
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        level <= DEPTH
    ) else $error("FIFO occupancy above its depth");

    // consumer side must never pop an empty queue
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en_i |-> !empty_o
    ) else $error("FIFO read requested while empty");

    // a write into an empty queue shows up at the head next cycle
    a_fall_through: assert property (
        @(posedge clk) disable iff (!rst_n)
        (empty_o && wr_en_i) |=> !empty_o
    ) else $error("FIFO stayed empty after a write");

endmodule

//--- design/arb_grant_engine.sv
// two-stage grant engine that resolves queued jobs into one-hot grants in four arbitration modes
`timescale 1ns/1ps
`include "arb_consts.svh"

module arb_grant_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  arb_job_pkg::arb_job_t job_i,
    input  logic                  empty_i,
    input  logic                  ready_i,
    output logic                  rd_en_o,
    output logic [`ARB_WIDTH-1:0] grant_o,
    output logic                  valid_o
);

    localparam int W  = `ARB_WIDTH;
    localparam int PW = $clog2(W);

    // stage 1 job register
    arb_job_pkg::arb_job_t s1_job;
    logic                  s1_valid;

    // arbitration state, updated in job order
    logic [PW-1:0] ptr;
    logic [PW-1:0] ptr_next;
    logic [W-1:0]  lfsr;
    logic [W-1:0]  lfsr_next;

    // candidates from stage 1
    logic [W-1:0] fixed_grant;
    logic [W-1:0] rr_grant;
    logic [W-1:0] prio_grant;
    logic [W-1:0] rand_grant;
    logic [W-1:0] prio_req;
    logic [W-1:0] rand_req;
    logic [W-1:0] sel_grant;

    // request of the job in the output stage
    logic [W-1:0] out_req;

    logic out_ready;
    logic s1_advance;
    logic s1_free;

    // isolate lowest set bit, zero stays zero
    function automatic logic [W-1:0] lowest_set(input logic [W-1:0] vec);
        return vec & (~vec + 1'b1);
    endfunction

    // first set bit searched circularly from start
    function automatic logic [W-1:0] rr_pick(input logic [W-1:0] vec,
                                             input logic [PW-1:0] start);
        logic [W-1:0] result;
        int           idx;
        result = '0;
        for (int k = 0; k < W; k++) begin
            idx = (int'(start) + k) % W;
            if (result == '0 && vec[idx]) begin
                result[idx] = 1'b1;
            end
        end
        return result;
    endfunction

    // handshake between stages
    assign out_ready  = !valid_o || ready_i;
    assign s1_advance = s1_valid && out_ready;
    assign s1_free    = !s1_valid || out_ready;
    assign rd_en_o    = !empty_i && s1_free;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (rd_en_o) begin
            s1_valid <= 1'b1;
        end else if (s1_advance) begin
            s1_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_o) begin
            s1_job <= job_i;
        end
    end

    assign prio_req    = s1_job.req & s1_job.cfg;
    assign rand_req    = s1_job.req & lfsr;
    assign fixed_grant = lowest_set(s1_job.req);
    assign rr_grant    = rr_pick(s1_job.req, ptr);
    assign prio_grant  = lowest_set(prio_req);
    // fall back to plain lowest request when the mask hides all of them
    assign rand_grant  = (rand_req != '0) ? lowest_set(rand_req) : lowest_set(s1_job.req);

    always_comb begin
        case (s1_job.mode)
            arb_mode_pkg::ARB_FIXED: sel_grant = fixed_grant;
            arb_mode_pkg::ARB_RR:    sel_grant = rr_grant;
            arb_mode_pkg::ARB_PRIO:  sel_grant = prio_grant;
            default:                 sel_grant = rand_grant;
        endcase
    end

    // pointer moves past the round-robin winner
    always_comb begin
        ptr_next = ptr;
        for (int i = 0; i < W; i++) begin
            if (rr_grant[i]) begin
                ptr_next = PW'((i + 1) % W);
            end
        end
    end

    assign lfsr_next = {lfsr[W-2:0], lfsr[W-1] ^ lfsr[W/2]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr  <= '0;
            lfsr <= W'(`ARB_LFSR_SEED);
        end else if (s1_advance) begin
            if (s1_job.mode == arb_mode_pkg::ARB_RR && rr_grant != '0) begin
                ptr <= ptr_next;
            end
            if (s1_job.mode == arb_mode_pkg::ARB_RAND) begin
                lfsr <= lfsr_next;
            end
        end
    end

    // output stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            grant_o <= '0;
        end else if (out_ready) begin
            valid_o <= s1_valid;
            if (s1_valid) begin
                grant_o <= sel_grant;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_advance) begin
            out_req <= s1_job.req;
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o |-> $onehot0(grant_o)
    ) else $error("grant_o not one-hot: %h", grant_o);

    a_grant_subset: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o |-> ((grant_o & ~out_req) == '0)
    ) else $error("grant_o %h outside request %h", grant_o, out_req);

    // stalled grant holds until taken
    a_grant_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_o && !ready_i) |=> (valid_o && $stable(grant_o))
    ) else $error("grant_o changed while stalled");

endmodule

//--- design/arb_subsystem.sv
// top level of the arbitration pipeline: sampler, job FIFO and grant engine in series
`timescale 1ns/1ps
`include "arb_consts.svh"

module arb_subsystem (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ARB_WIDTH-1:0]   req_i,
    input  arb_mode_pkg::arb_mode_e mode_i,
    input  logic [`ARB_WIDTH-1:0]   cfg_i,
    input  logic                    valid_i,
    input  logic                    ready_i,
    output logic                    ready_o,
    output logic [`ARB_WIDTH-1:0]   grant_o,
    output logic                    valid_o
);

    // sampler to queue
    logic                  wr_en;
    arb_job_pkg::arb_job_t wr_data;
    logic                  full;

    // queue to engine
    arb_job_pkg::arb_job_t rd_data;
    logic                  empty;
    logic                  rd_en;

    arb_req_sampler u_sampler (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_i     (req_i),
        .mode_i    (mode_i),
        .cfg_i     (cfg_i),
        .valid_i   (valid_i),
        .full_i    (full),
        .ready_o   (ready_o),
        .wr_en_o   (wr_en),
        .wr_data_o (wr_data)
    );

    arb_job_fifo #(
        .payload_t (arb_job_pkg::arb_job_t),
        .DEPTH     (`ARB_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_data_o (rd_data),
        .full_o    (full),
        .empty_o   (empty)
    );

    arb_grant_engine u_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .job_i   (rd_data),
        .empty_i (empty),
        .ready_i (ready_i),
        .rd_en_o (rd_en),
        .grant_o (grant_o),
        .valid_o (valid_o)
    );

endmodule

//--- bench/arb_subsystem_tb.sv
// testbench for the arbitration pipeline: random jobs in, grants checked against a model queue
`timescale 1ns/1ps
`include "arb_consts.svh"

module arb_subsystem_tb;

    localparam int W = `ARB_WIDTH;
    localparam int N_BASIC = 16;
    localparam int N_RR = 12;
    localparam int N_RAND = 12;
    localparam int N_STALL = 24;
    localparam int N_BURST = 12;
    localparam int TOTAL_JOBS = N_BASIC + N_RR + N_RAND + N_STALL + N_BURST;
    localparam int CYCLE_LIMIT = 64 * TOTAL_JOBS + 200;

    logic clk = 1'b0;
    logic rst_n;
    logic [W-1:0] req_i;
    arb_mode_pkg::arb_mode_e mode_i;
    logic [W-1:0] cfg_i;
    logic valid_i;
    logic ready_i;
    logic ready_o;
    logic [W-1:0] grant_o;
    logic valid_o;

    // reference model state
    logic [W-1:0] exp_q[$];
    logic [W-1:0] exp_head;
    int exp_count;
    int model_ptr;
    logic [W-1:0] model_mask;

    logic [31:0] rng_state = 32'h70d3;
    int errors = 0;
    int job_count = 0;
    int grant_count = 0;
    int cycle_count = 0;
    logic stall_mode = 1'b0;
    logic burst_on = 1'b0;
    logic saw_full = 1'b0;

    arb_subsystem dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_i   (req_i),
        .mode_i  (mode_i),
        .cfg_i   (cfg_i),
        .valid_i (valid_i),
        .ready_i (ready_i),
        .ready_o (ready_o),
        .grant_o (grant_o),
        .valid_o (valid_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // one-hot of the first set bit, scanning upward from start and wrapping
    function automatic logic [W-1:0] first_set_from(input logic [W-1:0] vec, input int start);
        logic [W-1:0] g;
        int idx;
        g = '0;
        for (int k = 0; k < W; k++) begin
            idx = (start + k) % W;
            if (g == '0 && vec[idx]) begin
                g[idx] = 1'b1;
            end
        end
        return g;
    endfunction

    task automatic model_job(input logic [W-1:0] req, input arb_mode_pkg::arb_mode_e mode,
                             input logic [W-1:0] cfg, output logic [W-1:0] grant);
        case (mode)
            arb_mode_pkg::ARB_FIXED: grant = first_set_from(req, 0);
            arb_mode_pkg::ARB_RR: begin
                grant = first_set_from(req, model_ptr);
                for (int i = 0; i < W; i++) begin
                    if (grant[i]) begin
                        model_ptr = (i + 1) % W;
                    end
                end
            end
            arb_mode_pkg::ARB_PRIO: grant = first_set_from(req & cfg, 0);
            default: begin
                if ((req & model_mask) != '0) begin
                    grant = first_set_from(req & model_mask, 0);
                end else begin
                    grant = first_set_from(req, 0);
                end
                model_mask = {model_mask[W-2:0], model_mask[W-1] ^ model_mask[W/2]};
            end
        endcase
    endtask

    // monitor, reads pre-edge values like a flop would
    always @(posedge clk or negedge rst_n) begin
        logic [W-1:0] g;
        if (!rst_n) begin
            exp_q.delete();
            model_ptr = 0;
            model_mask = W'(`ARB_LFSR_SEED);
            exp_head <= '0;
            exp_count <= 0;
        end else begin
            if (valid_o && ready_i) begin
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                grant_count++;
            end
            if (valid_i && ready_o) begin
                model_job(req_i, mode_i, cfg_i, g);
                exp_q.push_back(g);
                job_count++;
            end
            if (valid_i && !ready_o) begin
                saw_full = 1'b1;
            end
            exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
            exp_count <= exp_q.size();
        end
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) |-> (!valid_o && ready_o))
        else begin
            errors++;
            $display("pipeline not idle right after reset");
        end

    a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> (exp_count > 0))
        else begin
            errors++;
            $display("grant presented with no job outstanding");
        end

    a_grant_value: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_o && ready_i) |-> (grant_o == exp_head))
        else begin
            errors++;
            $display("Fail grant_o: got %h expected %h", $sampled(grant_o), $sampled(exp_head));
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_o && !ready_i) |=> (valid_o && $stable(grant_o)))
        else begin
            errors++;
            $display("grant changed or vanished while the output was stalled");
        end

    // empty pipeline: grant visible on the fourth edge after acceptance
    a_first_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_i && ready_o && exp_count == 0) |-> ##1 !valid_o [*3] ##1 valid_o)
        else begin
            errors++;
            $display("first grant did not arrive 4 cycles after acceptance");
        end

    a_burst_rate: assert property (@(posedge clk) disable iff (!rst_n)
        (burst_on && valid_o && ready_i && exp_count > 1) |=> valid_o)
        else begin
            errors++;
            $display("valid_o dropped inside a back-to-back burst");
        end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: grants still outstanding");
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic next_rand(output logic [31:0] r);
        rng_state = lcg_step(rng_state);
        r = rng_state;
    endtask

    // advance to the next falling edge, refreshing ready_i
    task automatic step();
        logic [31:0] r;
        @(negedge clk);
        if (stall_mode) begin
            next_rand(r);
            ready_i = (r[30:29] == 2'b11);
        end else begin
            ready_i = 1'b1;
        end
    endtask

    task automatic send_job(input logic [W-1:0] req, input arb_mode_pkg::arb_mode_e mode,
                            input logic [W-1:0] cfg);
        logic taken;
        req_i = req;
        mode_i = mode;
        cfg_i = cfg;
        valid_i = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            taken = ready_o;
            step();
        end
        valid_i = 1'b0;
    endtask

    task automatic send_random_job(input arb_mode_pkg::arb_mode_e mode);
        logic [31:0] r;
        next_rand(r);
        send_job(r[27:24], mode, r[23:20]);
    endtask

    task automatic send_any_job();
        logic [31:0] r;
        next_rand(r);
        send_job(r[27:24], arb_mode_pkg::arb_mode_e'(r[17:16]), r[23:20]);
    endtask

    task automatic drain_and_report(input int num, input string name);
        while (exp_count != 0) begin
            step();
        end
        repeat (4) step();
        $display("test %0d %s done, jobs %0d, errors %0d", num, name, job_count, errors);
    endtask

    initial begin
        rst_n = 1'b0;
        req_i = '0;
        mode_i = arb_mode_pkg::ARB_FIXED;
        cfg_i = '0;
        valid_i = 1'b0;
        ready_i = 1'b1;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        repeat (10) step();
        drain_and_report(1, "reset idle");

        for (int i = 0; i < 8; i++) begin
            send_random_job(arb_mode_pkg::ARB_FIXED);
        end
        for (int i = 0; i < 6; i++) begin
            send_random_job(arb_mode_pkg::ARB_PRIO);
        end
        send_job(4'b1100, arb_mode_pkg::ARB_PRIO, 4'b0011);
        send_job(4'b0000, arb_mode_pkg::ARB_FIXED, 4'b1111);
        drain_and_report(2, "fixed and priority");

        for (int i = 0; i < 2 * W; i++) begin
            send_job('1, arb_mode_pkg::ARB_RR, '0);
        end
        // gaps in the request, other modes in between
        send_job(4'b1010, arb_mode_pkg::ARB_RR, '0);
        send_job(4'b0001, arb_mode_pkg::ARB_FIXED, '0);
        send_job(4'b1010, arb_mode_pkg::ARB_RR, '0);
        send_job(4'b0001, arb_mode_pkg::ARB_PRIO, 4'b0001);
        drain_and_report(3, "round robin");

        for (int i = 0; i < N_RAND; i++) begin
            send_random_job(arb_mode_pkg::ARB_RAND);
        end
        drain_and_report(4, "lfsr masked");

        stall_mode = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            send_any_job();
        end
        drain_and_report(5, "output back-pressure");
        stall_mode = 1'b0;
        assert (saw_full) else begin
            errors++;
            $display("queue never filled enough to drop ready_o");
        end

        burst_on = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            send_any_job();
        end
        drain_and_report(6, "back-to-back");
        burst_on = 1'b0;

        assert (job_count == grant_count) else begin
            errors++;
            $display("accepted jobs and delivered grants differ in number");
        end
        $display("summary: %0d jobs, %0d grants, %0d errors", job_count, grant_count, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- arb_subsystem.f
+incdir+design
design/arb_mode_pkg.sv
design/arb_job_pkg.sv
design/arb_req_sampler.sv
design/arb_job_fifo.sv
design/arb_grant_engine.sv
design/arb_subsystem.sv
bench/arb_subsystem_tb.sv
